//--- Bender.yml
package:
  name: ita_controller

sources:
  - verilog/ita_pkg.sv
  - verilog/ita_step_fsm.sv
  - verilog/ita_flow_ctrl.sv
  - verilog/ita_edge_pad.sv
  - verilog/ita_controller.sv
  - target: test
    files:
      - testbench/tb_ita_controller.sv

//--- build.f
verilog/ita_pkg.sv
verilog/ita_step_fsm.sv
verilog/ita_flow_ctrl.sv
verilog/ita_edge_pad.sv
verilog/ita_controller.sv
testbench/tb_ita_controller.sv

//--- testbench/tb_ita_controller.sv
/* ita tile controller testbench
   directed Linear, Feedforward, flow control and edge padding tests */

`default_nettype none

module tb_ita_controller;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TileBeats = ita_pkg::TileBeats;
  localparam int unsigned M = ita_pkg::M;
  localparam int unsigned N = ita_pkg::N;
  // linear 4, feedforward 8, mirror 2, backpressure 1, edge pad 2 tile passes
  localparam int unsigned TotalBeats = (4 + 8 + 2 + 1 + 2) * TileBeats;
  localparam int unsigned WatchdogCycles = TotalBeats * 4;

  logic clk_i;
  logic rst_ni;
  ita_pkg::ctrl_t ctrl;
  logic inp_valid, weight_valid, bias_valid, oup_valid, oup_ready, requant_add;
  ita_pkg::bias_t [N-1:0] inp_bias;
  logic inp_ready, weight_ready, bias_ready, calc_en, busy;
  ita_pkg::step_e step;
  ita_pkg::pos_t pos;
  ita_pkg::bias_t [N-1:0] bias_pad;
  ita_pkg::requant_flag_t [N-1:0] requant_pad;

  logic [15:0] lfsr_q = 16'd40420;
  int errs = 0;
  int total_errs = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  ita_controller ita_controller_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .ctrl_i (ctrl),
    .inp_valid_i (inp_valid), .weight_valid_i (weight_valid), .bias_valid_i (bias_valid),
    .oup_valid_i (oup_valid), .oup_ready_i (oup_ready),
    .inp_bias_i (inp_bias), .requant_add_i (requant_add),
    .inp_ready_o (inp_ready), .weight_ready_o (weight_ready), .bias_ready_o (bias_ready),
    .calc_en_o (calc_en), .step_o (step), .pos_o (pos),
    .inp_bias_pad_o (bias_pad), .requant_add_pad_o (requant_pad), .busy_o (busy)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", WatchdogCycles);
    $display("Some tests failed");
    $finish;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("mismatch %s expected %0d actual %0d", what, exp, act);
      errs++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
    if (errs == 0) pass_cnt++;
    else fail_cnt++;
    total_errs += errs;
    errs = 0;
  endtask

  task automatic reset_dut();
    rst_ni = 1'b0;
    ctrl = '0;
    {inp_valid, weight_valid, bias_valid, oup_valid, oup_ready, requant_add} = '0;
    inp_bias = '0;
    repeat (2) @(posedge clk_i);
    #2 rst_ni = 1'b1;
  endtask

  task automatic set_ctrl(input ita_pkg::layer_e l, input int s, e, f, p, seq, ff, emb);
    ctrl = '0;
    ctrl.layer = l;
    ctrl.tile_s = s;
    ctrl.tile_e = e;
    ctrl.tile_f = f;
    ctrl.tile_p = p;
    ctrl.seq_length = seq;
    ctrl.ff_size = ff;
    ctrl.embed_size = emb;
  endtask

  // inner-tile limit, x wrap, tile total and next step per the step table
  task automatic limits_for(input ita_pkg::step_e st, output int lim, wrap, total,
                            output ita_pkg::step_e nxt);
    lim = 0;
    wrap = 0;
    total = 0;
    nxt = ita_pkg::Idle;
    case (st)
      ita_pkg::F1: begin
        lim = ctrl.tile_e;
        wrap = ctrl.tile_f;
        total = ctrl.tile_s * ctrl.tile_f;
        nxt = ita_pkg::F2;
      end
      ita_pkg::F2: begin
        lim = ctrl.tile_f;
        wrap = ctrl.tile_e;
        total = ctrl.tile_s * ctrl.tile_e;
      end
      ita_pkg::MatMul: begin
        lim = ctrl.tile_e;
        total = ctrl.tile_s * ctrl.tile_p;
      end
      default: ;
    endcase
  endtask

  // runs one layer from start to Idle against a reference model of the sequencer
  task automatic run_layer(input string name, input bit rand_valid, input int hold);
    ita_pkg::step_e exp_step, nxt;
    int lim, wrap, total, beat, inner, tx, ty, tile, beats, pending, cyc, exp_beats, row, cols;
    logic stall, acc, last, started, stalled, pad_en, keep;
    exp_step = ita_pkg::Idle;
    {beat, inner, tx, ty, tile, beats, pending, cyc} = '0;
    {started, stalled} = '0;
    exp_beats = (ctrl.layer == ita_pkg::Feedforward) ? 2 * ctrl.tile_s * ctrl.tile_e * ctrl.tile_f
                                                     : ctrl.tile_s * ctrl.tile_p * ctrl.tile_e;
    exp_beats = exp_beats * TileBeats;
    @(posedge clk_i);
    #2 ctrl.start = 1'b1;
    while (!(started && exp_step == ita_pkg::Idle)) begin
      inp_valid = rand_valid ? (rand_bits(2) != 0) : 1'b1;
      weight_valid = rand_valid ? (rand_bits(2) != 0) : 1'b1;
      bias_valid = rand_valid ? (rand_bits(2) != 0) : 1'b1;
      oup_ready = (cyc >= hold);
      oup_valid = (pending > 0);  // outputs only for counted results
      for (int i = 0; i < N; i++) inp_bias[i] = ita_pkg::bias_t'(rand_bits(24));
      requant_add = (rand_bits(1) != 0);
      @(negedge clk_i);
      limits_for(exp_step, lim, wrap, total, nxt);
      stall = (exp_step == ita_pkg::Idle) || (pending >= ita_pkg::FifoDepth);
      acc = !stall && inp_valid && weight_valid && bias_valid;
      last = (inner == lim - 1);
      check_eq({name, " step"}, exp_step, step);
      check_eq({name, " busy"}, exp_step != ita_pkg::Idle, busy);
      check_eq({name, " active"}, exp_step != ita_pkg::Idle, pos.active);
      check_eq({name, " inp_ready"}, !stall && weight_valid, inp_ready);
      check_eq({name, " weight_ready"}, !stall && inp_valid, weight_ready);
      check_eq({name, " bias_ready"}, !stall && weight_valid, bias_ready);
      check_eq({name, " calc_en"}, acc, calc_en);
      if (pos.active && weight_valid && !inp_ready) stalled = 1'b1;
      if (hold > 0 && cyc == hold) check_eq({name, " beats before release"},
                                            ita_pkg::FifoDepth, beats);
      if (calc_en) beats++;
      if (acc) begin
        check_eq({name, " inner_tile"}, inner, pos.inner_tile);
        check_eq({name, " first_inner"}, inner == 0, pos.first_inner);
        check_eq({name, " last_inner"}, last, pos.last_inner);
        check_eq({name, " tile_x"}, tx, pos.tile_x);
        check_eq({name, " tile_y"}, ty, pos.tile_y);
        pad_en = (exp_step == ita_pkg::F1) || (exp_step == ita_pkg::F2);
        cols = (exp_step == ita_pkg::F1) ? ctrl.ff_size : ctrl.embed_size;
        row = (beat % M) + ty * M;
        for (int i = 0; i < N; i++) begin
          keep = !pad_en || (row < ctrl.seq_length && tx * M + (beat / M) * N + i < cols);
          check_eq({name, " bias lane"}, keep ? inp_bias[i] : ita_pkg::bias_t'(0), bias_pad[i]);
          check_eq({name, " requant lane"}, keep && requant_add, requant_pad[i]);
        end
        if (beat == TileBeats - 1) begin
          beat = 0;
          inner++;
          if (inner == lim) begin
            inner = 0;
            tile++;
            if (exp_step != ita_pkg::MatMul) begin
              if (tx == wrap - 1) begin
                tx = 0;
                ty++;
              end else begin
                tx++;
              end
            end
            if (tile == total) begin
              {tile, tx, ty} = '0;
              exp_step = nxt;
            end
          end
        end else begin
          beat++;
        end
      end
      pending += int'(acc && last) - int'(oup_valid && oup_ready);
      if (exp_step == ita_pkg::Idle && ctrl.start) begin
        exp_step = (ctrl.layer == ita_pkg::Feedforward) ? ita_pkg::F1 : ita_pkg::MatMul;
        started = 1'b1;
      end
      @(posedge clk_i);
      #2 ctrl.start = 1'b0;
      cyc++;
    end
    check_eq({name, " final step"}, ita_pkg::Idle, step);
    check_eq({name, " final busy"}, 0, busy);
    check_eq({name, " accepted beats"}, exp_beats, beats);
    if (hold > 0) begin
      assert (stalled) else begin
        $display("%s: readys never dropped under output backpressure", name);
        errs++;
      end
    end
  endtask

  task automatic test_reset();
    reset_dut();
    {inp_valid, weight_valid, bias_valid} = 3'b111;  // valids alone start nothing
    repeat (3) begin
      @(negedge clk_i);
      check_eq("test_reset step", ita_pkg::Idle, step);
      check_eq("test_reset busy", 0, busy);
      check_eq("test_reset readys", 0, {inp_ready, weight_ready, bias_ready});
      check_eq("test_reset calc_en", 0, calc_en);
      check_eq("test_reset counters", 0, {pos.tile_x, pos.tile_y, pos.inner_tile});
      @(posedge clk_i);
      #2;
    end
    finish_test("test_reset");
  endtask

  task automatic test_linear();
    reset_dut();
    set_ctrl(ita_pkg::Linear, 2, 2, 1, 1, 16, 16, 16);
    run_layer("test_linear", 1'b0, 0);
    finish_test("test_linear");
  endtask

  task automatic test_feedforward();
    reset_dut();
    set_ctrl(ita_pkg::Feedforward, 2, 1, 2, 1, 16, 16, 8);
    run_layer("test_feedforward", 1'b0, 0);
    finish_test("test_feedforward");
  endtask

  task automatic test_ready_mirror();
    reset_dut();
    set_ctrl(ita_pkg::Linear, 1, 2, 1, 1, 8, 8, 8);
    run_layer("test_ready_mirror", 1'b1, 0);
    finish_test("test_ready_mirror");
  endtask

  task automatic test_backpressure();
    reset_dut();
    set_ctrl(ita_pkg::Linear, 1, 1, 1, 1, 8, 8, 8);  // every beat on a last inner tile
    run_layer("test_backpressure", 1'b0, 20);
    finish_test("test_backpressure");
  endtask

  task automatic test_edge_pad();
    reset_dut();
    set_ctrl(ita_pkg::Feedforward, 1, 1, 1, 1, 5, 6, 7);
    run_layer("test_edge_pad", 1'b0, 0);
    finish_test("test_edge_pad");
  endtask

  initial begin
    rst_ni = 1'b0;
    ctrl = '0;
    {inp_valid, weight_valid, bias_valid, oup_valid, oup_ready, requant_add} = '0;
    inp_bias = '0;
    test_reset();
    test_linear();
    test_feedforward();
    test_ready_mirror();
    test_backpressure();
    test_edge_pad();
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_cnt, fail_cnt, total_errs);
    if (fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ita_controller.sv
/* ita tile controller
   layer sequencer with beat flow control and edge padding of bias and requant */

`default_nettype none

module ita_controller (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  ita_pkg::ctrl_t                               ctrl_i,
  input  logic                                         inp_valid_i,
  input  logic                                         weight_valid_i,
  input  logic                                         bias_valid_i,
  input  logic                                         oup_valid_i,
  input  logic                                         oup_ready_i,
  input  ita_pkg::bias_t [ita_pkg::N-1:0]              inp_bias_i,
  input  logic                                         requant_add_i,
  output logic                                         inp_ready_o,
  output logic                                         weight_ready_o,
  output logic                                         bias_ready_o,
  output logic                                         calc_en_o,
  output ita_pkg::step_e                               step_o,
  output ita_pkg::pos_t                                pos_o,
  output ita_pkg::bias_t [ita_pkg::N-1:0]              inp_bias_pad_o,
  output ita_pkg::requant_flag_t [ita_pkg::N-1:0]      requant_add_pad_o,
  output logic                                         busy_o
);

  ita_pkg::edge_t    mat_edge;
  ita_pkg::counter_t count;
  logic              tile_done;

  ita_step_fsm ita_step_fsm_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl_i      (ctrl_i),
    .tile_done_i (tile_done),
    .step_o      (step_o),
    .pos_o       (pos_o),
    .edge_o      (mat_edge),
    .busy_o      (busy_o)
  );

  ita_flow_ctrl ita_flow_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .pos_i          (pos_o),
    .calc_en_o      (calc_en_o),
    .count_o        (count),
    .tile_done_o    (tile_done)
  );

  ita_edge_pad #(
    .lane_t (ita_pkg::bias_t)
  ) bias_pad_i (
    .lanes_i (inp_bias_i),
    .count_i (count),
    .pos_i   (pos_o),
    .edge_i  (mat_edge),
    .lanes_o (inp_bias_pad_o)
  );

  // requant flag is shared by all lanes of a beat
  ita_edge_pad #(
    .lane_t (ita_pkg::requant_flag_t)
  ) requant_pad_i (
    .lanes_i ({ita_pkg::N{requant_add_i}}),
    .count_i (count),
    .pos_i   (pos_o),
    .edge_i  (mat_edge),
    .lanes_o (requant_add_pad_o)
  );

endmodule

`default_nettype wire

//--- verilog/ita_edge_pad.sv
/* ita edge padding
   zeroes the lanes of an accepted beat that fall outside the matrix */

`default_nettype none

module ita_edge_pad #(
  parameter type lane_t = logic
) (
  input  lane_t [ita_pkg::N-1:0] lanes_i,
  input  ita_pkg::counter_t      count_i,
  input  ita_pkg::pos_t          pos_i,
  input  ita_pkg::edge_t         edge_i,
  output lane_t [ita_pkg::N-1:0] lanes_o
);

  ita_pkg::counter_t row;
  ita_pkg::counter_t row_in_tile;
  ita_pkg::counter_t row_base;
  ita_pkg::counter_t col_in_tile;
  ita_pkg::counter_t col_base;

  // beats walk down the rows first, then across lane groups
  assign row_in_tile = ita_pkg::counter_t'(count_i % ita_pkg::M);
  assign row_base    = ita_pkg::counter_t'(pos_i.tile_y * ita_pkg::M);
  assign row         = row_in_tile + row_base;

  assign col_in_tile = ita_pkg::counter_t'((count_i / ita_pkg::M) * ita_pkg::N);
  assign col_base    = ita_pkg::counter_t'(pos_i.tile_x * ita_pkg::M) + col_in_tile;

  always_comb begin
    lanes_o = lanes_i;
    if (edge_i.pad_en) begin
      if (row >= edge_i.rows) begin
        lanes_o = '0;   // whole row below the matrix
      end else begin
        for (int unsigned i = 0; i < ita_pkg::N; i++) begin
          if (col_base + i >= edge_i.cols) begin
            lanes_o[i] = '0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ita_flow_ctrl.sv
/* ita beat flow control
   ready gating, beat counter per tile and output credit tracking */

`default_nettype none

module ita_flow_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              inp_valid_i,
  input  logic              weight_valid_i,
  input  logic              bias_valid_i,
  output logic              inp_ready_o,
  output logic              weight_ready_o,
  output logic              bias_ready_o,
  input  logic              oup_valid_i,
  input  logic              oup_ready_i,
  input  ita_pkg::pos_t     pos_i,
  output logic              calc_en_o,
  output ita_pkg::counter_t count_o,
  output logic              tile_done_o
);

  ita_pkg::counter_t count_d, count_q;
  ita_pkg::counter_t credit_d, credit_q;
  logic              stall;
  logic              accept;
  logic              credit_inc;
  logic              out_hs;

  assign stall = !pos_i.active || (credit_q >= ita_pkg::FifoDepth);

  // readys mirror the partner valids
  always_comb begin
    inp_ready_o    = 1'b0;
    weight_ready_o = 1'b0;
    bias_ready_o   = 1'b0;
    if (!stall) begin
      inp_ready_o    = weight_valid_i;
      weight_ready_o = inp_valid_i;
      bias_ready_o   = weight_valid_i;
    end
  end

  assign accept      = !stall && inp_valid_i && weight_valid_i && bias_valid_i;
  assign calc_en_o   = accept;
  assign tile_done_o = accept && (count_q == ita_pkg::TileBeats - 1);

  always_comb begin
    count_d = count_q;
    if (tile_done_o) begin
      count_d = '0;
    end else if (accept) begin
      count_d = count_q + 1'b1;
    end
  end

  // results only leave on the last inner tile
  assign credit_inc = accept && pos_i.last_inner;
  assign out_hs     = oup_valid_i && oup_ready_i;

  always_comb begin
    credit_d = credit_q;
    if (credit_inc && !out_hs) begin
      credit_d = credit_q + 1'b1;
    end else if (out_hs && !credit_inc) begin
      credit_d = credit_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= '0;
      credit_q <= '0;
    end else begin
      count_q  <= count_d;
      credit_q <= credit_d;
    end
  end

  assign count_o = count_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= ita_pkg::FifoDepth)
    else $error("output credit above FIFO depth");

  // outputs must come from beats already counted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_hs |-> credit_q != '0)
    else $error("output handshake with no credit outstanding");

endmodule

`default_nettype wire

//--- verilog/ita_pkg.sv
/* ita tile sequencer package
   tile geometry, step and layer encodings, control and position structs */

`default_nettype none

package ita_pkg;

  // tile geometry
  localparam int unsigned M         = 8;          // tile edge
  localparam int unsigned N         = 4;          // lanes per beat
  localparam int unsigned TileBeats = M * M / N;
  localparam int unsigned FifoDepth = 8;          // outstanding result beats
  localparam int unsigned CntW      = 16;
  localparam int unsigned BiasW     = 24;

  typedef logic [CntW-1:0] counter_t;

  typedef enum logic [1:0] {
    Idle,
    MatMul,
    F1,
    F2
  } step_e;

  typedef enum logic {
    Linear,
    Feedforward
  } layer_e;

  // layer request with sizes in tiles except the matrix dims
  typedef struct packed {
    logic     start;
    layer_e   layer;
    counter_t tile_s;
    counter_t tile_e;
    counter_t tile_f;
    counter_t tile_p;
    counter_t seq_length;
    counter_t ff_size;
    counter_t embed_size;
  } ctrl_t;

  typedef struct packed {
    logic     pad_en;
    counter_t rows;
    counter_t cols;
  } edge_t;

  // where the sequencer is in the layer
  typedef struct packed {
    logic     active;
    counter_t tile_x;
    counter_t tile_y;
    counter_t inner_tile;
    logic     first_inner;
    logic     last_inner;
  } pos_t;

  typedef logic signed [BiasW-1:0] bias_t;

  typedef logic requant_flag_t;

endpackage

`default_nettype wire

//--- verilog/ita_step_fsm.sv
/* ita step sequencer
   walks steps, output tiles and inner tiles of a Linear or Feedforward layer */

`default_nettype none

module ita_step_fsm (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ita_pkg::ctrl_t ctrl_i,
  input  logic           tile_done_i,
  output ita_pkg::step_e step_o,
  output ita_pkg::pos_t  pos_o,
  output ita_pkg::edge_t edge_o,
  output logic           busy_o
);

  ita_pkg::step_e    step_d, step_q;
  ita_pkg::counter_t tile_d, tile_q;
  ita_pkg::counter_t tile_x_d, tile_x_q;
  ita_pkg::counter_t tile_y_d, tile_y_q;
  ita_pkg::counter_t inner_d, inner_q;
  logic              busy_d, busy_q;

  ita_pkg::counter_t inner_lim;
  ita_pkg::counter_t x_wrap;
  ita_pkg::counter_t tile_total;
  ita_pkg::step_e    step_next;
  logic              walk_en;

  // per-step limits
  always_comb begin
    inner_lim  = '0;
    x_wrap     = '0;
    tile_total = '0;
    step_next  = ita_pkg::Idle;
    walk_en    = 1'b0;
    case (step_q)
      ita_pkg::F1: begin
        inner_lim  = ctrl_i.tile_e;
        x_wrap     = ctrl_i.tile_f;
        tile_total = ctrl_i.tile_s * ctrl_i.tile_f;
        step_next  = ita_pkg::F2;
        walk_en    = 1'b1;
      end
      ita_pkg::F2: begin
        inner_lim  = ctrl_i.tile_f;
        x_wrap     = ctrl_i.tile_e;
        tile_total = ctrl_i.tile_s * ctrl_i.tile_e;
        walk_en    = 1'b1;
      end
      ita_pkg::MatMul: begin
        inner_lim  = ctrl_i.tile_e;
        tile_total = ctrl_i.tile_s * ctrl_i.tile_p;   // no x/y walk here
      end
      default: ;
    endcase
  end

  always_comb begin
    step_d   = step_q;
    tile_d   = tile_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    inner_d  = inner_q;
    busy_d   = busy_q;
    if (step_q == ita_pkg::Idle) begin
      if (ctrl_i.start) begin
        step_d = (ctrl_i.layer == ita_pkg::Feedforward) ? ita_pkg::F1 : ita_pkg::MatMul;
        busy_d = 1'b1;
      end
    end else if (tile_done_i) begin
      inner_d = inner_q + 1'b1;
      if (inner_d == inner_lim) begin   // output tile finished
        inner_d = '0;
        tile_d  = tile_q + 1'b1;
        if (walk_en) begin
          if (tile_x_q == x_wrap - 1'b1) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
          end else begin
            tile_x_d = tile_x_q + 1'b1;
          end
        end
        if (tile_d == tile_total) begin   // end of step
          tile_d   = '0;
          tile_x_d = '0;
          tile_y_d = '0;
          step_d   = step_next;
          if (step_next == ita_pkg::Idle) begin
            busy_d = 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= ita_pkg::Idle;
      tile_q   <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      inner_q  <= '0;
      busy_q   <= 1'b0;
    end else begin
      step_q   <= step_d;
      tile_q   <= tile_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
      inner_q  <= inner_d;
      busy_q   <= busy_d;
    end
  end

  always_comb begin
    pos_o.active      = (step_q != ita_pkg::Idle);
    pos_o.tile_x      = tile_x_q;
    pos_o.tile_y      = tile_y_q;
    pos_o.inner_tile  = inner_q;
    pos_o.first_inner = (inner_q == '0);
    pos_o.last_inner  = pos_o.active && (inner_q == inner_lim - 1'b1);
    edge_o.pad_en     = (step_q == ita_pkg::F1) || (step_q == ita_pkg::F2);
    edge_o.rows       = ctrl_i.seq_length;
    edge_o.cols       = (step_q == ita_pkg::F1) ? ctrl_i.ff_size : ctrl_i.embed_size;
  end

  assign step_o = step_q;
  assign busy_o = busy_q;

  // no layer without a start pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_q == ita_pkg::Idle && !ctrl_i.start) |=> step_q == ita_pkg::Idle)
    else $error("step left Idle without start");

endmodule

`default_nettype wire
